//--- verilog/dual_issue_pkg.sv
`default_nettype none

package dual_issue_pkg;

    // Datapath and register file geometry
    localparam int xlen       = 32;
    localparam int reg_num    = 32;
    localparam int reg_addr_w = 5;
    localparam int imm_w      = 16;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [xlen-1:0]       pc_t;
    typedef logic [imm_w-1:0]      imm_t;

    // ALU operations handled by both execute lanes
    typedef enum logic [2:0] {
        op_add  = 3'd0,
        op_sub  = 3'd1,
        op_and  = 3'd2,
        op_or   = 3'd3,
        op_xor  = 3'd4,
        op_slt  = 3'd5,  // Signed compare, result is 0 or 1
        op_addi = 3'd6,  // rs plus sign-extended immediate
        op_lui  = 3'd7   // Immediate placed in the upper half
    } alu_op_t;

    // Issue controller states
    typedef enum logic {
        st_pair   = 1'b0,  // Normal dual issue
        st_second = 1'b1   // Slot 0 of a split pair already went out
    } issue_state_t;

endpackage

`default_nettype wire

//--- verilog/regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile (
    input  wire                             clk,
    input  wire                             rst,

    // Write port 1 comes from lane 0, write port 2 from lane 1
    input  wire dual_issue_pkg::pc_t        pc_i_1,
    input  wire                             we_1,
    input  wire dual_issue_pkg::reg_addr_t  waddr_1,
    input  wire dual_issue_pkg::word_t      wdata_1,
    input  wire dual_issue_pkg::pc_t        pc_i_2,
    input  wire                             we_2,
    input  wire dual_issue_pkg::reg_addr_t  waddr_2,
    input  wire dual_issue_pkg::word_t      wdata_2,

    // rs operand reads for lane 0 and lane 1
    input  wire                             re1_1,
    input  wire dual_issue_pkg::reg_addr_t  raddr1_1,
    output dual_issue_pkg::word_t           rdata1_1,
    input  wire                             re1_2,
    input  wire dual_issue_pkg::reg_addr_t  raddr1_2,
    output dual_issue_pkg::word_t           rdata1_2,

    // rt operand reads for lane 0 and lane 1
    input  wire                             re2_1,
    input  wire dual_issue_pkg::reg_addr_t  raddr2_1,
    output dual_issue_pkg::word_t           rdata2_1,
    input  wire                             re2_2,
    input  wire dual_issue_pkg::reg_addr_t  raddr2_2,
    output dual_issue_pkg::word_t           rdata2_2
);

    dual_issue_pkg::word_t regs [dual_issue_pkg::reg_num];

    logic same_addr;  // Both lanes write the same register this cycle
    logic pc1_newer;  // Lane 0 holds the younger instruction

    assign same_addr = we_1 && we_2 && (waddr_1 == waddr_2);
    assign pc1_newer = pc_i_1 > pc_i_2;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < dual_issue_pkg::reg_num; i++) begin
                regs[i] <= '0;
            end
        end else if (same_addr) begin
            // Program order decides which of the two results survives
            if (waddr_1 != '0) begin
                regs[waddr_1] <= pc1_newer ? wdata_1 : wdata_2;
            end
        end else begin
            if (we_1 && (waddr_1 != '0)) begin
                regs[waddr_1] <= wdata_1;
            end
            if (we_2 && (waddr_2 != '0)) begin
                regs[waddr_2] <= wdata_2;
            end
        end
    end

    // One read port with bypass from the results being written back
    function automatic dual_issue_pkg::word_t read_port(
        input logic                      re,
        input dual_issue_pkg::reg_addr_t raddr
    );
        logic hit_1;
        logic hit_2;
        hit_1 = we_1 && (waddr_1 == raddr);
        hit_2 = we_2 && (waddr_2 == raddr);
        if (!re || (raddr == '0)) begin
            return '0;
        end
        if (hit_1 && hit_2) begin
            return pc1_newer ? wdata_1 : wdata_2;
        end
        if (hit_1) begin
            return wdata_1;
        end
        if (hit_2) begin
            return wdata_2;
        end
        return regs[raddr];
    endfunction

    always_comb begin
        rdata1_1 = read_port(re1_1, raddr1_1);
        rdata1_2 = read_port(re1_2, raddr1_2);
        rdata2_1 = read_port(re2_1, raddr2_1);
        rdata2_2 = read_port(re2_2, raddr2_2);
    end

endmodule

`default_nettype wire

//--- verilog/exec_lane.sv
`timescale 1ns/1ns
`default_nettype none

module exec_lane (
    input  wire                             clk,
    input  wire                             rst,

    input  wire                             iss_valid,
    input  wire dual_issue_pkg::alu_op_t    iss_op,
    input  wire dual_issue_pkg::pc_t        iss_pc,
    input  wire dual_issue_pkg::reg_addr_t  iss_rd,
    input  wire dual_issue_pkg::imm_t       iss_imm,
    input  wire dual_issue_pkg::word_t      rs_data,
    input  wire dual_issue_pkg::word_t      rt_data,

    output logic                            res_valid,
    output dual_issue_pkg::pc_t             res_pc,
    output dual_issue_pkg::reg_addr_t       res_rd,
    output dual_issue_pkg::word_t           res_data
);

    localparam int pad_w = dual_issue_pkg::xlen - dual_issue_pkg::imm_w;

    dual_issue_pkg::word_t imm_sext;
    dual_issue_pkg::word_t imm_upper;
    dual_issue_pkg::word_t operand_b;
    dual_issue_pkg::word_t alu_result;

    assign imm_sext  = {{pad_w{iss_imm[dual_issue_pkg::imm_w-1]}}, iss_imm};
    assign imm_upper = {iss_imm, {pad_w{1'b0}}};

    // Second operand is rt for register ops and the immediate otherwise
    always_comb begin
        case (iss_op)
            dual_issue_pkg::op_addi: operand_b = imm_sext;
            dual_issue_pkg::op_lui:  operand_b = imm_upper;
            default:                 operand_b = rt_data;
        endcase
    end

    always_comb begin
        case (iss_op)
            dual_issue_pkg::op_add,
            dual_issue_pkg::op_addi: alu_result = rs_data + operand_b;
            dual_issue_pkg::op_sub:  alu_result = rs_data - operand_b;
            dual_issue_pkg::op_and:  alu_result = rs_data & operand_b;
            dual_issue_pkg::op_or:   alu_result = rs_data | operand_b;
            dual_issue_pkg::op_xor:  alu_result = rs_data ^ operand_b;
            dual_issue_pkg::op_slt: begin
                if ($signed(rs_data) < $signed(operand_b)) begin
                    alu_result = dual_issue_pkg::word_t'(1);
                end else begin
                    alu_result = '0;
                end
            end
            dual_issue_pkg::op_lui:  alu_result = operand_b;  // rs is not read
            default:                 alu_result = '0;
        endcase
    end

    // Write-back stage register
    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= iss_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid) begin
            res_pc   <= iss_pc;
            res_rd   <= iss_rd;
            res_data <= alu_result;
        end
    end

endmodule

`default_nettype wire

//--- verilog/issue_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module issue_ctrl (
    input  wire                             clk,
    input  wire                             rst,

    input  wire                             in_valid,
    output logic                            in_ready,
    input  wire dual_issue_pkg::pc_t        in_pc_0,
    input  wire dual_issue_pkg::alu_op_t    in_op_0,
    input  wire dual_issue_pkg::reg_addr_t  in_rs_0,
    input  wire dual_issue_pkg::reg_addr_t  in_rt_0,
    input  wire dual_issue_pkg::reg_addr_t  in_rd_0,
    input  wire dual_issue_pkg::imm_t       in_imm_0,
    input  wire dual_issue_pkg::pc_t        in_pc_1,
    input  wire dual_issue_pkg::alu_op_t    in_op_1,
    input  wire dual_issue_pkg::reg_addr_t  in_rs_1,
    input  wire dual_issue_pkg::reg_addr_t  in_rt_1,
    input  wire dual_issue_pkg::reg_addr_t  in_rd_1,
    input  wire dual_issue_pkg::imm_t       in_imm_1,

    output logic                            re1_1,
    output dual_issue_pkg::reg_addr_t       raddr1_1,
    output logic                            re2_1,
    output dual_issue_pkg::reg_addr_t       raddr2_1,
    output logic                            re1_2,
    output dual_issue_pkg::reg_addr_t       raddr1_2,
    output logic                            re2_2,
    output dual_issue_pkg::reg_addr_t       raddr2_2,
    input  wire dual_issue_pkg::word_t      rdata1_1,
    input  wire dual_issue_pkg::word_t      rdata2_1,
    input  wire dual_issue_pkg::word_t      rdata1_2,
    input  wire dual_issue_pkg::word_t      rdata2_2,

    output logic                            iss_valid_0,
    output dual_issue_pkg::alu_op_t         iss_op_0,
    output dual_issue_pkg::pc_t             iss_pc_0,
    output dual_issue_pkg::reg_addr_t       iss_rd_0,
    output dual_issue_pkg::imm_t            iss_imm_0,
    output dual_issue_pkg::word_t           rs_data_0,
    output dual_issue_pkg::word_t           rt_data_0,
    output logic                            iss_valid_1,
    output dual_issue_pkg::alu_op_t         iss_op_1,
    output dual_issue_pkg::pc_t             iss_pc_1,
    output dual_issue_pkg::reg_addr_t       iss_rd_1,
    output dual_issue_pkg::imm_t            iss_imm_1,
    output dual_issue_pkg::word_t           rs_data_1,
    output dual_issue_pkg::word_t           rt_data_1
);

    dual_issue_pkg::issue_state_t state;
    dual_issue_pkg::issue_state_t state_next;
    logic                         conflict;

    function automatic logic uses_rs(input dual_issue_pkg::alu_op_t op);
        return op != dual_issue_pkg::op_lui;
    endfunction

    function automatic logic uses_rt(input dual_issue_pkg::alu_op_t op);
        return (op != dual_issue_pkg::op_addi) && (op != dual_issue_pkg::op_lui);
    endfunction

    // Slot 1 needs a result that slot 0 of the same pair produces
    assign conflict = (in_rd_0 != '0) &&
                      ((uses_rs(in_op_1) && (in_rs_1 == in_rd_0)) ||
                       (uses_rt(in_op_1) && (in_rt_1 == in_rd_0)));

    always_comb begin
        state_next = state;
        case (state)
            dual_issue_pkg::st_pair: begin
                if (in_valid && conflict) begin
                    state_next = dual_issue_pkg::st_second;
                end
            end
            dual_issue_pkg::st_second: begin
                if (in_valid) begin
                    state_next = dual_issue_pkg::st_pair;
                end
            end
            default: state_next = dual_issue_pkg::st_pair;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dual_issue_pkg::st_pair;
        end else begin
            state <= state_next;
        end
    end

    // The pair is only consumed once slot 1 has gone out
    assign in_ready    = (state == dual_issue_pkg::st_second) || !(in_valid && conflict);
    assign iss_valid_0 = in_valid && (state == dual_issue_pkg::st_pair);
    assign iss_valid_1 = in_valid && ((state == dual_issue_pkg::st_second) || !conflict);

    assign re1_1    = iss_valid_0 && uses_rs(in_op_0);
    assign re2_1    = iss_valid_0 && uses_rt(in_op_0);
    assign re1_2    = iss_valid_1 && uses_rs(in_op_1);
    assign re2_2    = iss_valid_1 && uses_rt(in_op_1);
    assign raddr1_1 = in_rs_0;
    assign raddr2_1 = in_rt_0;
    assign raddr1_2 = in_rs_1;
    assign raddr2_2 = in_rt_1;

    assign iss_op_0  = in_op_0;
    assign iss_pc_0  = in_pc_0;
    assign iss_rd_0  = in_rd_0;
    assign iss_imm_0 = in_imm_0;
    assign rs_data_0 = rdata1_1;
    assign rt_data_0 = rdata2_1;

    assign iss_op_1  = in_op_1;
    assign iss_pc_1  = in_pc_1;
    assign iss_rd_1  = in_rd_1;
    assign iss_imm_1 = in_imm_1;
    assign rs_data_1 = rdata1_2;  // Bypassed from lane 0 when split
    assign rt_data_1 = rdata2_2;

endmodule

`default_nettype wire

//--- verilog/dual_issue_core.sv
`timescale 1ns/1ns
`default_nettype none

module dual_issue_core (
    input  wire                             clk,
    input  wire                             rst,

    input  wire                             in_valid,
    output wire                             in_ready,
    input  wire dual_issue_pkg::pc_t        in_pc_0,
    input  wire dual_issue_pkg::alu_op_t    in_op_0,
    input  wire dual_issue_pkg::reg_addr_t  in_rs_0,
    input  wire dual_issue_pkg::reg_addr_t  in_rt_0,
    input  wire dual_issue_pkg::reg_addr_t  in_rd_0,
    input  wire dual_issue_pkg::imm_t       in_imm_0,
    input  wire dual_issue_pkg::pc_t        in_pc_1,
    input  wire dual_issue_pkg::alu_op_t    in_op_1,
    input  wire dual_issue_pkg::reg_addr_t  in_rs_1,
    input  wire dual_issue_pkg::reg_addr_t  in_rt_1,
    input  wire dual_issue_pkg::reg_addr_t  in_rd_1,
    input  wire dual_issue_pkg::imm_t       in_imm_1,

    output wire                             commit_valid_0,
    output dual_issue_pkg::pc_t             commit_pc_0,
    output dual_issue_pkg::reg_addr_t       commit_rd_0,
    output dual_issue_pkg::word_t           commit_data_0,
    output wire                             commit_valid_1,
    output dual_issue_pkg::pc_t             commit_pc_1,
    output dual_issue_pkg::reg_addr_t       commit_rd_1,
    output dual_issue_pkg::word_t           commit_data_1
);

    logic                      re1_1;
    logic                      re2_1;
    logic                      re1_2;
    logic                      re2_2;
    dual_issue_pkg::reg_addr_t raddr1_1;
    dual_issue_pkg::reg_addr_t raddr2_1;
    dual_issue_pkg::reg_addr_t raddr1_2;
    dual_issue_pkg::reg_addr_t raddr2_2;
    dual_issue_pkg::word_t     rdata1_1;
    dual_issue_pkg::word_t     rdata2_1;
    dual_issue_pkg::word_t     rdata1_2;
    dual_issue_pkg::word_t     rdata2_2;

    logic                      iss_valid_0;
    dual_issue_pkg::alu_op_t   iss_op_0;
    dual_issue_pkg::pc_t       iss_pc_0;
    dual_issue_pkg::reg_addr_t iss_rd_0;
    dual_issue_pkg::imm_t      iss_imm_0;
    dual_issue_pkg::word_t     rs_data_0;
    dual_issue_pkg::word_t     rt_data_0;
    logic                      iss_valid_1;
    dual_issue_pkg::alu_op_t   iss_op_1;
    dual_issue_pkg::pc_t       iss_pc_1;
    dual_issue_pkg::reg_addr_t iss_rd_1;
    dual_issue_pkg::imm_t      iss_imm_1;
    dual_issue_pkg::word_t     rs_data_1;
    dual_issue_pkg::word_t     rt_data_1;

    issue_ctrl issue_ctrl_i (
        .clk, .rst, .in_valid, .in_ready,
        .in_pc_0, .in_op_0, .in_rs_0, .in_rt_0, .in_rd_0, .in_imm_0,
        .in_pc_1, .in_op_1, .in_rs_1, .in_rt_1, .in_rd_1, .in_imm_1,
        .re1_1, .raddr1_1, .re2_1, .raddr2_1, .re1_2, .raddr1_2, .re2_2, .raddr2_2,
        .rdata1_1, .rdata2_1, .rdata1_2, .rdata2_2,
        .iss_valid_0, .iss_op_0, .iss_pc_0, .iss_rd_0, .iss_imm_0, .rs_data_0, .rt_data_0,
        .iss_valid_1, .iss_op_1, .iss_pc_1, .iss_rd_1, .iss_imm_1, .rs_data_1, .rt_data_1
    );

    // Lane outputs are the commit ports and the write-back ports at once
    exec_lane lane_0 (
        .clk, .rst,
        .iss_valid(iss_valid_0), .iss_op(iss_op_0), .iss_pc(iss_pc_0),
        .iss_rd(iss_rd_0), .iss_imm(iss_imm_0), .rs_data(rs_data_0), .rt_data(rt_data_0),
        .res_valid(commit_valid_0), .res_pc(commit_pc_0),
        .res_rd(commit_rd_0), .res_data(commit_data_0)
    );

    exec_lane lane_1 (
        .clk, .rst,
        .iss_valid(iss_valid_1), .iss_op(iss_op_1), .iss_pc(iss_pc_1),
        .iss_rd(iss_rd_1), .iss_imm(iss_imm_1), .rs_data(rs_data_1), .rt_data(rt_data_1),
        .res_valid(commit_valid_1), .res_pc(commit_pc_1),
        .res_rd(commit_rd_1), .res_data(commit_data_1)
    );

    regfile regfile_i (
        .clk, .rst,
        .pc_i_1(commit_pc_0), .we_1(commit_valid_0),
        .waddr_1(commit_rd_0), .wdata_1(commit_data_0),
        .pc_i_2(commit_pc_1), .we_2(commit_valid_1),
        .waddr_2(commit_rd_1), .wdata_2(commit_data_1),
        .re1_1, .raddr1_1, .rdata1_1, .re1_2, .raddr1_2, .rdata1_2,
        .re2_1, .raddr2_1, .rdata2_1, .re2_2, .raddr2_2, .rdata2_2
    );

endmodule

`default_nettype wire

//--- tb/dual_issue_core_checker.sv
`timescale 1ns/1ns
`default_nettype none

module dual_issue_core_checker (
    input wire                            clk,
    input wire                            rst,
    input wire                            in_valid,
    input wire                            in_ready,
    input wire dual_issue_pkg::pc_t       in_pc_0,
    input wire dual_issue_pkg::alu_op_t   in_op_0,
    input wire dual_issue_pkg::reg_addr_t in_rs_0,
    input wire dual_issue_pkg::reg_addr_t in_rt_0,
    input wire dual_issue_pkg::reg_addr_t in_rd_0,
    input wire dual_issue_pkg::imm_t      in_imm_0,
    input wire dual_issue_pkg::pc_t       in_pc_1,
    input wire dual_issue_pkg::alu_op_t   in_op_1,
    input wire dual_issue_pkg::reg_addr_t in_rs_1,
    input wire dual_issue_pkg::reg_addr_t in_rt_1,
    input wire dual_issue_pkg::reg_addr_t in_rd_1,
    input wire dual_issue_pkg::imm_t      in_imm_1,
    input wire                            commit_valid_0,
    input wire                            commit_valid_1
);

    commit_idle_after_reset: assert property (
        @(posedge clk) rst |=> !commit_valid_0 && !commit_valid_1
    ) else $error("commit_valid is high in the cycle after reset");

    // A stalled pair must be held unchanged by the producer
    fields_stable_while_stalled: assert property (
        @(posedge clk) disable iff (rst)
        (in_valid && !in_ready) |=>
            $stable(in_pc_0) && $stable(in_op_0) && $stable(in_rs_0) && $stable(in_rt_0) &&
            $stable(in_rd_0) && $stable(in_imm_0) && $stable(in_pc_1) && $stable(in_op_1) &&
            $stable(in_rs_1) && $stable(in_rt_1) && $stable(in_rd_1) && $stable(in_imm_1)
    ) else $error("input pair changed while waiting for in_ready");

    single_stall_cycle: assert property (
        @(posedge clk) disable iff (rst) !in_ready |=> in_ready
    ) else $error("in_ready stayed low for two cycles");

endmodule

bind dual_issue_core dual_issue_core_checker dual_issue_core_checker_i (
    .clk, .rst, .in_valid, .in_ready,
    .in_pc_0, .in_op_0, .in_rs_0, .in_rt_0, .in_rd_0, .in_imm_0,
    .in_pc_1, .in_op_1, .in_rs_1, .in_rt_1, .in_rd_1, .in_imm_1,
    .commit_valid_0, .commit_valid_1
);

`default_nettype wire

//--- tb/dual_issue_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dual_issue_core_tb;

    localparam int clk_period      = 100;
    localparam int directed_pairs  = 38;
    localparam int random_pairs    = 400;
    localparam int watchdog_cycles = (directed_pairs + random_pairs) * 2 + 100;

    logic                      clk;
    logic                      rst;
    logic                      in_valid;
    logic                      in_ready;
    dual_issue_pkg::pc_t       in_pc_0;
    dual_issue_pkg::alu_op_t   in_op_0;
    dual_issue_pkg::reg_addr_t in_rs_0;
    dual_issue_pkg::reg_addr_t in_rt_0;
    dual_issue_pkg::reg_addr_t in_rd_0;
    dual_issue_pkg::imm_t      in_imm_0;
    dual_issue_pkg::pc_t       in_pc_1;
    dual_issue_pkg::alu_op_t   in_op_1;
    dual_issue_pkg::reg_addr_t in_rs_1;
    dual_issue_pkg::reg_addr_t in_rt_1;
    dual_issue_pkg::reg_addr_t in_rd_1;
    dual_issue_pkg::imm_t      in_imm_1;
    logic                      commit_valid_0;
    dual_issue_pkg::pc_t       commit_pc_0;
    dual_issue_pkg::reg_addr_t commit_rd_0;
    dual_issue_pkg::word_t     commit_data_0;
    logic                      commit_valid_1;
    dual_issue_pkg::pc_t       commit_pc_1;
    dual_issue_pkg::reg_addr_t commit_rd_1;
    dual_issue_pkg::word_t     commit_data_1;

    dual_issue_pkg::word_t     shadow [dual_issue_pkg::reg_num];  // Registers in program order
    dual_issue_pkg::pc_t       exp_pc_q [$];
    dual_issue_pkg::reg_addr_t exp_rd_q [$];
    dual_issue_pkg::word_t     exp_data_q [$];
    int                        exp_cycle_q [$];
    string                     exp_name_q [$];
    dual_issue_pkg::pc_t       next_pc;
    string                     test_name;
    int                        cycle_count;  // Falling edges seen so far
    int                        errors;
    int                        missing;
    bit                        timed_out;
    int                        seed;

    dual_issue_core dual_issue_core_i (
        .clk, .rst, .in_valid, .in_ready,
        .in_pc_0, .in_op_0, .in_rs_0, .in_rt_0, .in_rd_0, .in_imm_0,
        .in_pc_1, .in_op_1, .in_rs_1, .in_rt_1, .in_rd_1, .in_imm_1,
        .commit_valid_0, .commit_pc_0, .commit_rd_0, .commit_data_0,
        .commit_valid_1, .commit_pc_1, .commit_rd_1, .commit_data_1
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic dual_issue_pkg::word_t alu_ref(
        input dual_issue_pkg::alu_op_t op,
        input dual_issue_pkg::word_t   a,
        input dual_issue_pkg::word_t   b,
        input dual_issue_pkg::imm_t    imm
    );
        case (op)
            dual_issue_pkg::op_add:  return a + b;
            dual_issue_pkg::op_sub:  return a - b;
            dual_issue_pkg::op_and:  return a & b;
            dual_issue_pkg::op_or:   return a | b;
            dual_issue_pkg::op_xor:  return a ^ b;
            dual_issue_pkg::op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            dual_issue_pkg::op_addi: return a + {{16{imm[15]}}, imm};
            dual_issue_pkg::op_lui:  return {imm, 16'h0000};
            default:                 return '0;
        endcase
    endfunction

    // Slot 1 must wait when an operand it reads is slot 0's nonzero destination
    function automatic bit needs_split(
        input dual_issue_pkg::alu_op_t   op1,
        input dual_issue_pkg::reg_addr_t rs1,
        input dual_issue_pkg::reg_addr_t rt1,
        input dual_issue_pkg::reg_addr_t rd0
    );
        bit reads_rs;
        bit reads_rt;
        reads_rs = (op1 != dual_issue_pkg::op_lui);
        reads_rt = (op1 != dual_issue_pkg::op_addi) && (op1 != dual_issue_pkg::op_lui);
        return (rd0 != '0) && ((reads_rs && (rs1 == rd0)) || (reads_rt && (rt1 == rd0)));
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic model_instr(
        input dual_issue_pkg::alu_op_t   op,
        input dual_issue_pkg::reg_addr_t rs,
        input dual_issue_pkg::reg_addr_t rt,
        input dual_issue_pkg::reg_addr_t rd,
        input dual_issue_pkg::imm_t      imm,
        input dual_issue_pkg::pc_t       pc,
        input int                        cycle
    );
        dual_issue_pkg::word_t result;
        result = alu_ref(op, shadow[rs], shadow[rt], imm);
        exp_pc_q.push_back(pc);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(result);
        exp_cycle_q.push_back(cycle);
        exp_name_q.push_back(test_name);
        if (rd != '0) begin
            shadow[rd] = result;
        end
    endtask

    // Called right after a rising edge, returns at the edge that takes the pair
    task automatic send_pair(
        input dual_issue_pkg::alu_op_t op0, input int rs0, input int rt0, input int rd0,
        input int imm0,
        input dual_issue_pkg::alu_op_t op1, input int rs1, input int rt1, input int rd1,
        input int imm1,
        output bit split
    );
        dual_issue_pkg::pc_t pc0;
        int                  stalls;
        int                  commit_cycle;
        bit                  expect_split;
        pc0 = next_pc;
        stalls = 0;
        expect_split = needs_split(op1, 5'(rs1), 5'(rt1), 5'(rd0));
        commit_cycle = cycle_count + 2;  // Slot 0 shows in the cycle after the next edge
        in_valid <= 1'b1;
        in_pc_0  <= pc0;
        in_op_0  <= op0;
        in_rs_0  <= 5'(rs0);
        in_rt_0  <= 5'(rt0);
        in_rd_0  <= 5'(rd0);
        in_imm_0 <= 16'(imm0);
        in_pc_1  <= pc0 + 32'd4;
        in_op_1  <= op1;
        in_rs_1  <= 5'(rs1);
        in_rt_1  <= 5'(rt1);
        in_rd_1  <= 5'(rd1);
        in_imm_1 <= 16'(imm1);
        // A split pair commits slot 0 before the pair itself is accepted
        model_instr(op0, 5'(rs0), 5'(rt0), 5'(rd0), 16'(imm0), pc0, commit_cycle);
        model_instr(op1, 5'(rs1), 5'(rt1), 5'(rd1), 16'(imm1), pc0 + 32'd4,
                    commit_cycle + (expect_split ? 1 : 0));
        next_pc = next_pc + 32'd8;
        @(negedge clk);
        while (!in_ready) begin
            stalls++;
            @(negedge clk);
        end
        @(posedge clk);
        check_value({test_name, " stall cycles"}, expect_split ? 32'd1 : 32'd0, 32'(stalls));
        split = expect_split;
    endtask

    task automatic compare_commit(input dual_issue_pkg::pc_t pc,
                                  input dual_issue_pkg::reg_addr_t rd,
                                  input dual_issue_pkg::word_t data);
        string name;
        if (exp_pc_q.size() == 0) begin
            errors++;
            $display("A commit at pc %h arrived with no instruction outstanding", pc);
        end else begin
            name = exp_name_q.pop_front();
            check_value({name, " pc"}, exp_pc_q.pop_front(), pc);
            check_value({name, " rd"}, 32'(exp_rd_q.pop_front()), 32'(rd));
            check_value({name, " data"}, exp_data_q.pop_front(), data);
            check_value({name, " commit cycle"}, exp_cycle_q.pop_front(), cycle_count);
        end
    endtask

    task automatic report_and_finish;
        missing = exp_pc_q.size();
        $display("errors: %0d, missing commits: %0d", errors, missing);
        if ((errors == 0) && (missing == 0) && !timed_out) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    // Lane 0 always holds the older instruction of a cycle
    initial begin
        forever begin
            @(negedge clk);
            cycle_count++;
            if (!rst && commit_valid_0) compare_commit(commit_pc_0, commit_rd_0, commit_data_0);
            if (!rst && commit_valid_1) compare_commit(commit_pc_1, commit_rd_1, commit_data_1);
        end
    end

    initial begin
        #(watchdog_cycles * clk_period);
        timed_out = 1'b1;
        $display("Timeout: commits stopped arriving, %0d still outstanding", exp_pc_q.size());
        report_and_finish();
    end

    initial begin
        bit                    split;
        dual_issue_pkg::word_t r0;
        dual_issue_pkg::word_t r1;
        dual_issue_pkg::word_t r2;
        seed = 32'h3f142b44;
        errors = 0;
        cycle_count = 0;
        timed_out = 1'b0;
        next_pc = 32'h0000_1000;
        for (int i = 0; i < dual_issue_pkg::reg_num; i++) shadow[i] = '0;
        rst = 1'b1;
        in_valid = 1'b0;
        {in_pc_0, in_rs_0, in_rt_0, in_rd_0, in_imm_0} = '0;
        {in_pc_1, in_rs_1, in_rt_1, in_rd_1, in_imm_1} = '0;
        in_op_0 = dual_issue_pkg::op_add;
        in_op_1 = dual_issue_pkg::op_add;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("reset in_ready", 32'd1, 32'(in_ready));
        @(posedge clk);

        test_name = "reset state";
        for (int k = 0; k < 16; k++) begin
            send_pair(dual_issue_pkg::op_or, 2 * k, 0, 0, 0,
                      dual_issue_pkg::op_or, 2 * k + 1, 0, 0, 0, split);
        end

        test_name = "independent pairs";  // r1 is negative so slt sees both signs
        send_pair(dual_issue_pkg::op_lui, 0, 0, 1, 'h8001,
                  dual_issue_pkg::op_addi, 0, 0, 2, 'hfff3, split);
        send_pair(dual_issue_pkg::op_addi, 0, 0, 3, 'h1234,
                  dual_issue_pkg::op_lui, 0, 0, 4, 'h7ff0, split);
        for (int k = 0; k < 8; k++) begin
            send_pair(dual_issue_pkg::alu_op_t'(3'(k)), 1, 2, 9, 'h9000 + k,
                      dual_issue_pkg::alu_op_t'(3'(k + 3)), 3, 4, 10, 'h0111 * k, split);
        end

        test_name = "split pair";
        send_pair(dual_issue_pkg::op_add, 1, 2, 11, 0, dual_issue_pkg::op_sub, 11, 3, 12, 0, split);
        send_pair(dual_issue_pkg::op_xor, 4, 3, 13, 0, dual_issue_pkg::op_and, 2, 13, 14, 0, split);
        send_pair(dual_issue_pkg::op_addi, 3, 0, 15, 7,
                  dual_issue_pkg::op_addi, 1, 15, 16, 'hff00, split);
        send_pair(dual_issue_pkg::op_or, 1, 2, 17, 0,
                  dual_issue_pkg::op_lui, 17, 0, 18, 'h00a5, split);

        test_name = "same destination";
        send_pair(dual_issue_pkg::op_addi, 0, 0, 5, 'h1234,
                  dual_issue_pkg::op_addi, 0, 0, 5, 'h5678, split);
        send_pair(dual_issue_pkg::op_or, 5, 0, 19, 0, dual_issue_pkg::op_add, 5, 5, 20, 0, split);
        send_pair(dual_issue_pkg::op_addi, 0, 0, 6, 1, dual_issue_pkg::op_addi, 6, 0, 6, 2, split);
        send_pair(dual_issue_pkg::op_or, 6, 0, 21, 0, dual_issue_pkg::op_slt, 6, 5, 22, 0, split);

        test_name = "forwarding";
        send_pair(dual_issue_pkg::op_addi, 1, 0, 7, 'h0101,
                  dual_issue_pkg::op_sub, 2, 3, 8, 0, split);
        send_pair(dual_issue_pkg::op_add, 7, 8, 23, 0, dual_issue_pkg::op_xor, 8, 7, 24, 0, split);
        send_pair(dual_issue_pkg::op_addi, 1, 0, 0, 5, dual_issue_pkg::op_or, 0, 0, 25, 0, split);
        send_pair(dual_issue_pkg::op_add, 0, 0, 26, 0, dual_issue_pkg::op_slt, 0, 2, 27, 0, split);

        test_name = "random run";
        for (int n = 0; n < random_pairs; n++) begin
            r0 = $random(seed);
            r1 = $random(seed);
            r2 = $random(seed);
            send_pair(dual_issue_pkg::alu_op_t'(r0[2:0]), int'(r0[5:3]), int'(r0[8:6]),
                      int'(r0[11:9]), int'(r0[31:16]),
                      dual_issue_pkg::alu_op_t'(r1[2:0]), int'(r1[5:3]), int'(r1[8:6]),
                      int'(r1[11:9]), int'(r1[31:16]), split);
            if (!split && (r2[1:0] == 2'b00)) begin
                in_valid <= 1'b0;  // A gap keeps each pair within two cycles
                @(posedge clk);
            end
        end

        in_valid <= 1'b0;
        while (exp_pc_q.size() != 0) @(negedge clk);
        repeat (2) @(posedge clk);
        report_and_finish();
    end

endmodule

`default_nettype wire

//--- dual_issue_core.f
verilog/dual_issue_pkg.sv
verilog/regfile.sv
verilog/exec_lane.sv
verilog/issue_ctrl.sv
verilog/dual_issue_core.sv
tb/dual_issue_core_checker.sv
tb/dual_issue_core_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= dual_issue_core_tb
RTL_TOP    ?= dual_issue_core
FILELIST   ?= dual_issue_core.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall
PASS_TEXT  ?= Simulation finished: PASS
RTL_SRCS   ?= verilog/dual_issue_pkg.sv verilog/regfile.sv verilog/exec_lane.sv \
              verilog/issue_ctrl.sv verilog/dual_issue_core.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
